//--- axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int AddrWidth  = 16;
  localparam int DataWidth  = 32;
  localparam int StrbWidth  = DataWidth / 8;
  localparam int IdWidth    = 4;
  localparam int MemBytes   = 1024;
  localparam int QueueDepth = 4;

  // Derived sizes for the word array and the queue pointers
  localparam int MemWords      = MemBytes / StrbWidth;
  localparam int LaneBits      = $clog2(StrbWidth);
  localparam int WordBits      = $clog2(MemWords);
  localparam int QueuePtrBits  = $clog2(QueueDepth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [7:0]           len_t;
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           burst_t;
  typedef logic [1:0]           resp_t;

  localparam burst_t BurstFixed = 2'b00;
  localparam burst_t BurstIncr  = 2'b01;
  localparam burst_t BurstWrap  = 2'b10;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespExOkay = 2'b01;
  localparam resp_t RespSlvErr = 2'b10;
  localparam resp_t RespDecErr = 2'b11;

  // One AW or AR request as held in the queues
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } burst_req_t;

  function automatic addr_t beat_addr(burst_req_t req, len_t beat);
    addr_t bytes;
    addr_t aligned;
    addr_t step;
    addr_t wrap_mask;
    bytes     = addr_t'(1) << req.size;
    aligned   = req.addr & ~(bytes - addr_t'(1));
    step      = addr_t'(beat) << req.size;
    wrap_mask = ((addr_t'(req.len) + addr_t'(1)) << req.size) - addr_t'(1);
    beat_addr = req.addr;
    if (req.burst == BurstIncr && beat != '0) begin
      beat_addr = aligned + step;
    end else if (req.burst == BurstWrap) begin
      // Window base keeps the high bits, the offset rolls over inside it
      beat_addr = (req.addr & ~wrap_mask) | ((aligned + step) & wrap_mask);
    end
  endfunction

  function automatic strb_t beat_lanes(addr_t addr, size_t size);
    int bytes;
    int lower;
    int upper;
    bytes = 1 << size;
    if (bytes > StrbWidth) begin
      bytes = StrbWidth;
    end
    lower = int'(addr) % StrbWidth;
    // Upper lane ends the size-aligned chunk that holds the start lane
    upper = (lower / bytes) * bytes + bytes - 1;
    for (int i = 0; i < StrbWidth; i++) begin
      beat_lanes[i] = (i >= lower) && (i <= upper);
    end
  endfunction

  function automatic resp_t resp_precedence(resp_t a, resp_t b);
    logic [1:0] rank_a;
    logic [1:0] rank_b;
    // EXOKAY sits below OKAY, the error codes already rank by encoding
    rank_a = (a == RespOkay) ? 2'd1 : (a == RespExOkay) ? 2'd0 : a;
    rank_b = (b == RespOkay) ? 2'd1 : (b == RespExOkay) ? 2'd0 : b;
    resp_precedence = (rank_a >= rank_b) ? a : b;
  endfunction

endpackage

`default_nettype wire

//--- mem_port_if.sv
`default_nettype none

// One byte-strobed access port of the memory array
interface mem_port_if;

  logic                en;
  logic                we;
  axi_mem_pkg::addr_t  addr;
  axi_mem_pkg::data_t  wdata;
  axi_mem_pkg::strb_t  strb;
  // Registered, valid the cycle after en
  axi_mem_pkg::data_t  rdata;

  modport engine (
    output en, we, addr, wdata, strb,
    input  rdata
  );

  modport memory (
    input  en, we, addr, wdata, strb,
    output rdata
  );

endinterface

`default_nettype wire

//--- beat_mon_if.sv
`default_nettype none

// Record of one accepted beat on a channel
interface beat_mon_if;

  logic                valid;
  axi_mem_pkg::addr_t  addr;
  axi_mem_pkg::data_t  data;
  axi_mem_pkg::id_t    id;
  axi_mem_pkg::len_t   beat_count;
  logic                last;

  modport source (output valid, addr, data, id, beat_count, last);

  modport sink (input valid, addr, data, id, beat_count, last);

endinterface

`default_nettype wire

//--- axi_req_queue.sv
`default_nettype none

module axi_req_queue #(
  parameter type payload_t = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic push_valid_i,
  output logic      push_ready_o,
  input  payload_t  push_data_i,
  output logic      head_valid_o,
  output payload_t  head_o,
  input  wire logic pop_i
);

  payload_t entries [axi_mem_pkg::QueueDepth];

  logic [axi_mem_pkg::QueuePtrBits-1:0] wr_ptr_q;
  logic [axi_mem_pkg::QueuePtrBits-1:0] rd_ptr_q;
  logic [axi_mem_pkg::QueuePtrBits:0]   count_q;
  logic                                 push;

  assign push_ready_o = count_q != (axi_mem_pkg::QueuePtrBits + 1)'(axi_mem_pkg::QueueDepth);
  assign head_valid_o = count_q != '0;
  assign head_o       = entries[rd_ptr_q];
  assign push         = push_valid_i && push_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap naturally since the depth is a power of two
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop_i) count_q <= count_q + 1'b1;
      else if (!push && pop_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) entries[wr_ptr_q] <= push_data_i;
  end

  // The engine only retires a request it has been working on
  assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> head_valid_o);

endmodule

`default_nettype wire

//--- axi_write_engine.sv
`default_nettype none

module axi_write_engine (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic                      req_valid_i,
  input  axi_mem_pkg::burst_req_t        req_i,
  output logic                           req_pop_o,
  input  wire logic                      w_valid_i,
  output logic                           w_ready_o,
  input  axi_mem_pkg::data_t             w_data_i,
  input  axi_mem_pkg::strb_t             w_strb_i,
  input  wire logic                      w_last_i,
  output logic                           b_valid_o,
  input  wire logic                      b_ready_i,
  output axi_mem_pkg::id_t               b_id_o,
  output axi_mem_pkg::resp_t             b_resp_o,
  mem_port_if.engine                     mem,
  beat_mon_if.source                     mon
);

  axi_mem_pkg::len_t  beat_cnt_q;
  axi_mem_pkg::resp_t resp_acc_q;
  logic               b_pending_q;
  axi_mem_pkg::id_t   b_id_q;
  axi_mem_pkg::resp_t b_resp_q;

  axi_mem_pkg::addr_t cur_addr;
  axi_mem_pkg::resp_t beat_resp;
  axi_mem_pkg::resp_t resp_next;
  logic               in_range;
  logic               last_beat;
  logic               w_fire;

  // Hold off W while the previous burst still owes its B response
  assign w_ready_o = req_valid_i && !b_pending_q;
  assign w_fire    = w_valid_i && w_ready_o;

  assign cur_addr  = axi_mem_pkg::beat_addr(req_i, beat_cnt_q);
  assign in_range  = cur_addr < axi_mem_pkg::addr_t'(axi_mem_pkg::MemBytes);
  assign beat_resp = in_range ? axi_mem_pkg::RespOkay : axi_mem_pkg::RespSlvErr;
  assign resp_next = axi_mem_pkg::resp_precedence(resp_acc_q, beat_resp);
  assign last_beat = beat_cnt_q == req_i.len;
  assign req_pop_o = w_fire && last_beat;

  // Out-of-range beats leave the array untouched
  assign mem.en    = w_fire && in_range;
  assign mem.we    = 1'b1;
  assign mem.addr  = cur_addr;
  assign mem.wdata = w_data_i;
  assign mem.strb  = w_strb_i & axi_mem_pkg::beat_lanes(cur_addr, req_i.size);

  assign b_valid_o = b_pending_q;
  assign b_id_o    = b_id_q;
  assign b_resp_o  = b_resp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_cnt_q  <= '0;
      resp_acc_q  <= axi_mem_pkg::RespOkay;
      b_pending_q <= 1'b0;
      mon.valid   <= 1'b0;
    end else begin
      mon.valid <= w_fire;
      if (b_pending_q && b_ready_i) b_pending_q <= 1'b0;
      if (w_fire) begin
        if (last_beat) begin
          beat_cnt_q  <= '0;
          resp_acc_q  <= axi_mem_pkg::RespOkay;
          b_pending_q <= 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
          resp_acc_q <= resp_next;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_fire) begin
      mon.addr       <= cur_addr;
      mon.data       <= w_data_i;
      mon.id         <= req_i.id;
      mon.beat_count <= beat_cnt_q;
      mon.last       <= last_beat;
      if (last_beat) begin
        b_id_q   <= req_i.id;
        b_resp_q <= resp_next;
      end
    end
  end

  // Manager's last flag agrees with the length of the AW at the head
  assert property (@(posedge clk_i) disable iff (rst_i) w_fire |-> (w_last_i == last_beat));

endmodule

`default_nettype wire

//--- axi_read_engine.sv
`default_nettype none

module axi_read_engine (
  input  wire logic                      clk_i,
  input  wire logic                      rst_i,
  input  wire logic                      req_valid_i,
  input  axi_mem_pkg::burst_req_t        req_i,
  output logic                           req_pop_o,
  output logic                           r_valid_o,
  input  wire logic                      r_ready_i,
  output axi_mem_pkg::id_t               r_id_o,
  output axi_mem_pkg::data_t             r_data_o,
  output axi_mem_pkg::resp_t             r_resp_o,
  output logic                           r_last_o,
  mem_port_if.engine                     mem,
  beat_mon_if.source                     mon
);

  typedef enum logic [1:0] {
    StIdle,
    StFetch,
    StPresent
  } state_e;

  state_e             state_q;
  axi_mem_pkg::len_t  beat_cnt_q;
  axi_mem_pkg::addr_t cur_addr;
  logic               in_range;
  logic               r_fire;

  // Head request and beat count stay put from fetch until the transfer
  assign cur_addr = axi_mem_pkg::beat_addr(req_i, beat_cnt_q);
  assign in_range = cur_addr < axi_mem_pkg::addr_t'(axi_mem_pkg::MemBytes);

  assign mem.en    = state_q == StFetch;
  assign mem.we    = 1'b0;
  assign mem.addr  = cur_addr;
  assign mem.wdata = '0;
  assign mem.strb  = '0;

  assign r_valid_o = state_q == StPresent;
  assign r_id_o    = req_i.id;
  assign r_data_o  = in_range ? mem.rdata : '0;
  assign r_resp_o  = in_range ? axi_mem_pkg::RespOkay : axi_mem_pkg::RespSlvErr;
  assign r_last_o  = beat_cnt_q == req_i.len;
  assign r_fire    = r_valid_o && r_ready_i;
  assign req_pop_o = r_fire && r_last_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= StIdle;
      beat_cnt_q <= '0;
      mon.valid  <= 1'b0;
    end else begin
      mon.valid <= r_fire;
      case (state_q)
        StIdle: if (req_valid_i) state_q <= StFetch;
        StFetch: state_q <= StPresent;
        StPresent: begin
          if (r_fire) begin
            if (r_last_o) begin
              state_q    <= StIdle;
              beat_cnt_q <= '0;
            end else begin
              state_q    <= StFetch;
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      mon.addr       <= cur_addr;
      mon.data       <= r_data_o;
      mon.id         <= r_id_o;
      mon.beat_count <= beat_cnt_q;
      mon.last       <= r_last_o;
    end
  end

  // A presented beat may not change or vanish before the manager takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_id_o, r_data_o, r_resp_o, r_last_o}));

endmodule

`default_nettype wire

//--- axi_byte_mem.sv
`default_nettype none

module axi_byte_mem (
  input  wire logic  clk_i,
  mem_port_if.memory wr,
  mem_port_if.memory rd
);

  logic [axi_mem_pkg::StrbWidth-1:0][7:0] mem_q [axi_mem_pkg::MemWords];

  logic [axi_mem_pkg::WordBits-1:0] wr_idx;
  logic [axi_mem_pkg::WordBits-1:0] rd_idx;

  // Byte address drops the lane bits to select a word
  assign wr_idx = wr.addr[axi_mem_pkg::LaneBits +: axi_mem_pkg::WordBits];
  assign rd_idx = rd.addr[axi_mem_pkg::LaneBits +: axi_mem_pkg::WordBits];

  always_ff @(posedge clk_i) begin
    if (wr.en) begin
      for (int i = 0; i < axi_mem_pkg::StrbWidth; i++) begin
        if (wr.we && wr.strb[i]) mem_q[wr_idx][i] <= wr.wdata[i*8 +: 8];
      end
    end
    // Old word when the write port hits the same word in this cycle
    if (rd.en) begin
      rd.rdata <= mem_q[rd_idx];
    end
  end

endmodule

`default_nettype wire

//--- axi_mem_top.sv
`default_nettype none

module axi_mem_top (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire logic                aw_valid_i,
  output logic                     aw_ready_o,
  input  axi_mem_pkg::id_t         aw_id_i,
  input  axi_mem_pkg::addr_t       aw_addr_i,
  input  axi_mem_pkg::len_t        aw_len_i,
  input  axi_mem_pkg::size_t       aw_size_i,
  input  axi_mem_pkg::burst_t      aw_burst_i,
  input  wire logic                w_valid_i,
  output logic                     w_ready_o,
  input  axi_mem_pkg::data_t       w_data_i,
  input  axi_mem_pkg::strb_t       w_strb_i,
  input  wire logic                w_last_i,
  output logic                     b_valid_o,
  input  wire logic                b_ready_i,
  output axi_mem_pkg::id_t         b_id_o,
  output axi_mem_pkg::resp_t       b_resp_o,
  input  wire logic                ar_valid_i,
  output logic                     ar_ready_o,
  input  axi_mem_pkg::id_t         ar_id_i,
  input  axi_mem_pkg::addr_t       ar_addr_i,
  input  axi_mem_pkg::len_t        ar_len_i,
  input  axi_mem_pkg::size_t       ar_size_i,
  input  axi_mem_pkg::burst_t      ar_burst_i,
  output logic                     r_valid_o,
  input  wire logic                r_ready_i,
  output axi_mem_pkg::id_t         r_id_o,
  output axi_mem_pkg::data_t       r_data_o,
  output axi_mem_pkg::resp_t       r_resp_o,
  output logic                     r_last_o,
  output logic                     mon_w_valid_o,
  output axi_mem_pkg::addr_t       mon_w_addr_o,
  output axi_mem_pkg::data_t       mon_w_data_o,
  output axi_mem_pkg::id_t         mon_w_id_o,
  output axi_mem_pkg::len_t        mon_w_beat_count_o,
  output logic                     mon_w_last_o,
  output logic                     mon_r_valid_o,
  output axi_mem_pkg::addr_t       mon_r_addr_o,
  output axi_mem_pkg::data_t       mon_r_data_o,
  output axi_mem_pkg::id_t         mon_r_id_o,
  output axi_mem_pkg::len_t        mon_r_beat_count_o,
  output logic                     mon_r_last_o
);

  axi_mem_pkg::burst_req_t aw_req;
  axi_mem_pkg::burst_req_t ar_req;
  axi_mem_pkg::burst_req_t aw_head;
  axi_mem_pkg::burst_req_t ar_head;
  logic                    aw_head_valid;
  logic                    ar_head_valid;
  logic                    aw_pop;
  logic                    ar_pop;

  mem_port_if u_wr_port ();
  mem_port_if u_rd_port ();
  beat_mon_if u_mon_w ();
  beat_mon_if u_mon_r ();

  assign aw_req = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i, size: aw_size_i,
                    burst: aw_burst_i};
  assign ar_req = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i, size: ar_size_i,
                    burst: ar_burst_i};

  axi_req_queue #(.payload_t(axi_mem_pkg::burst_req_t)) u_aw_queue (
    .clk_i, .rst_i,
    .push_valid_i (aw_valid_i),
    .push_ready_o (aw_ready_o),
    .push_data_i  (aw_req),
    .head_valid_o (aw_head_valid),
    .head_o       (aw_head),
    .pop_i        (aw_pop)
  );

  axi_req_queue #(.payload_t(axi_mem_pkg::burst_req_t)) u_ar_queue (
    .clk_i, .rst_i,
    .push_valid_i (ar_valid_i),
    .push_ready_o (ar_ready_o),
    .push_data_i  (ar_req),
    .head_valid_o (ar_head_valid),
    .head_o       (ar_head),
    .pop_i        (ar_pop)
  );

  axi_write_engine u_write_engine (
    .clk_i, .rst_i,
    .req_valid_i (aw_head_valid),
    .req_i       (aw_head),
    .req_pop_o   (aw_pop),
    .w_valid_i, .w_ready_o, .w_data_i, .w_strb_i, .w_last_i,
    .b_valid_o, .b_ready_i, .b_id_o, .b_resp_o,
    .mem         (u_wr_port.engine),
    .mon         (u_mon_w.source)
  );

  axi_read_engine u_read_engine (
    .clk_i, .rst_i,
    .req_valid_i (ar_head_valid),
    .req_i       (ar_head),
    .req_pop_o   (ar_pop),
    .r_valid_o, .r_ready_i, .r_id_o, .r_data_o, .r_resp_o, .r_last_o,
    .mem         (u_rd_port.engine),
    .mon         (u_mon_r.source)
  );

  axi_byte_mem u_mem (
    .clk_i,
    .wr (u_wr_port.memory),
    .rd (u_rd_port.memory)
  );

  assign mon_w_valid_o      = u_mon_w.valid;
  assign mon_w_addr_o       = u_mon_w.addr;
  assign mon_w_data_o       = u_mon_w.data;
  assign mon_w_id_o         = u_mon_w.id;
  assign mon_w_beat_count_o = u_mon_w.beat_count;
  assign mon_w_last_o       = u_mon_w.last;
  assign mon_r_valid_o      = u_mon_r.valid;
  assign mon_r_addr_o       = u_mon_r.addr;
  assign mon_r_data_o       = u_mon_r.data;
  assign mon_r_id_o         = u_mon_r.id;
  assign mon_r_beat_count_o = u_mon_r.beat_count;
  assign mon_r_last_o       = u_mon_r.last;

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`default_nettype none

module tb_axi_mem;

  // One row of the transaction table
  typedef struct packed {
    bit wr;
    bit chain;
    int id;
    int addr;
    int len;
    int size;
    int burst;
    bit rand_strb;
    int stall;
    int resp;
  } txn_t;

  logic        clk_i;
  logic        rst_i;
  logic        aw_valid_i;
  logic        aw_ready_o;
  logic [3:0]  aw_id_i;
  logic [15:0] aw_addr_i;
  logic [7:0]  aw_len_i;
  logic [2:0]  aw_size_i;
  logic [1:0]  aw_burst_i;
  logic        w_valid_i;
  logic        w_ready_o;
  logic [31:0] w_data_i;
  logic [3:0]  w_strb_i;
  logic        w_last_i;
  logic        b_valid_o;
  logic        b_ready_i;
  logic [3:0]  b_id_o;
  logic [1:0]  b_resp_o;
  logic        ar_valid_i;
  logic        ar_ready_o;
  logic [3:0]  ar_id_i;
  logic [15:0] ar_addr_i;
  logic [7:0]  ar_len_i;
  logic [2:0]  ar_size_i;
  logic [1:0]  ar_burst_i;
  logic        r_valid_o;
  logic        r_ready_i;
  logic [3:0]  r_id_o;
  logic [31:0] r_data_o;
  logic [1:0]  r_resp_o;
  logic        r_last_o;
  logic        mon_w_valid_o;
  logic [15:0] mon_w_addr_o;
  logic [31:0] mon_w_data_o;
  logic [3:0]  mon_w_id_o;
  logic [7:0]  mon_w_beat_count_o;
  logic        mon_w_last_o;
  logic        mon_r_valid_o;
  logic [15:0] mon_r_addr_o;
  logic [31:0] mon_r_data_o;
  logic [3:0]  mon_r_id_o;
  logic [7:0]  mon_r_beat_count_o;
  logic        mon_r_last_o;

  txn_t        txns[$];
  logic [7:0]  ref_mem [axi_mem_pkg::MemBytes];
  logic [31:0] lcg_state;
  int          err_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 1000;
  int          mon_w_count = 0;
  int          mon_r_count = 0;

  axi_mem_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // Each monitor record must show up for exactly one cycle per beat
  always @(negedge clk_i) begin
    if (mon_w_valid_o === 1'b1) mon_w_count = mon_w_count + 1;
    if (mon_r_valid_o === 1'b1) mon_r_count = mon_r_count + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic bit ready_roll(int stall);
    logic [31:0] r;
    r = lcg_next();
    return ((r >> 16) & 32'd3) >= 32'(stall);
  endfunction

  function automatic int beat_address(txn_t t, int n);
    int nbytes;
    int aligned;
    int window;
    nbytes  = 1 << t.size;
    aligned = (t.addr / nbytes) * nbytes;
    window  = (t.len + 1) * nbytes;
    if (t.burst == 0) return t.addr;
    if (t.burst == 1) return (n == 0) ? t.addr : aligned + n * nbytes;
    // WRAP window is aligned to its own size
    return (t.addr / window) * window + (aligned + n * nbytes) % window;
  endfunction

  function automatic logic [31:0] lane_keep(int addr, int size);
    int nbytes;
    int first;
    int i;
    logic [31:0] keep;
    nbytes = (size > 2) ? 4 : (1 << size);
    first  = addr % 4;
    keep   = '0;
    for (i = 0; i < 4; i++) begin
      // From the start byte up to the end of its size-aligned chunk
      if (i >= first && i / nbytes == first / nbytes) keep[i*8 +: 8] = 8'hFF;
    end
    return keep;
  endfunction

  function automatic logic [31:0] ref_word(int addr);
    logic [31:0] word;
    int i;
    for (i = 0; i < 4; i++) word[i*8 +: 8] = ref_mem[(addr / 4) * 4 + i];
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Address phases of a group go out back to back
  task automatic issue_addrs(input int first, input int last);
    txn_t t;
    int k;
    for (k = first; k <= last; k++) begin
      t = txns[k];
      if (t.wr) begin
        aw_valid_i = 1'b1;
        aw_id_i    = 4'(t.id);
        aw_addr_i  = 16'(t.addr);
        aw_len_i   = 8'(t.len);
        aw_size_i  = 3'(t.size);
        aw_burst_i = 2'(t.burst);
      end else begin
        ar_valid_i = 1'b1;
        ar_id_i    = 4'(t.id);
        ar_addr_i  = 16'(t.addr);
        ar_len_i   = 8'(t.len);
        ar_size_i  = 3'(t.size);
        ar_burst_i = 2'(t.burst);
      end
      #30;
      while (!(t.wr ? aw_ready_o : ar_ready_o)) #40;
      @(posedge clk_i);
      #5;
    end
    aw_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    // Nothing has retired yet, so a group of queue depth leaves the queue full
    if (last - first + 1 == axi_mem_pkg::QueueDepth) begin
      if (t.wr) begin
        check_value("aw_ready when full", 32'(aw_ready_o), 32'd0);
      end else begin
        check_value("ar_ready when full", 32'(ar_ready_o), 32'd0);
      end
    end
  endtask

  task automatic write_burst(input txn_t t);
    int n;
    int addr;
    int i;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] keep;
    for (n = 0; n <= t.len; n++) begin
      addr = beat_address(t, n);
      data = lcg_next();
      strb = t.rand_strb ? 4'(lcg_next() >> 12) : 4'hF;
      keep = lane_keep(addr, t.size);
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      w_last_i  = (n == t.len);
      #30;
      while (!w_ready_o) #40;
      @(posedge clk_i);
      #5;
      // Only strobed bytes inside the beat's lanes land in memory
      if (addr < axi_mem_pkg::MemBytes) begin
        for (i = 0; i < 4; i++) begin
          if (strb[i] && keep[i*8]) ref_mem[(addr / 4) * 4 + i] = data[i*8 +: 8];
        end
      end
      check_value("mon_w_valid", 32'(mon_w_valid_o), 32'd1);
      check_value("mon_w_addr", 32'(mon_w_addr_o), addr);
      check_value("mon_w_data", mon_w_data_o, data);
      check_value("mon_w_id", 32'(mon_w_id_o), t.id);
      check_value("mon_w_beat_count", 32'(mon_w_beat_count_o), n);
      check_value("mon_w_last", 32'(mon_w_last_o), 32'(n == t.len));
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic take_b(input txn_t t);
    bit done;
    done = 1'b0;
    while (!done) begin
      b_ready_i = ready_roll(t.stall);
      #30;
      if (b_valid_o && b_ready_i) begin
        check_value("b_id", 32'(b_id_o), t.id);
        check_value("b_resp", 32'(b_resp_o), t.resp);
        done = 1'b1;
      end
      @(posedge clk_i);
      #5;
    end
    b_ready_i = 1'b0;
  endtask

  task automatic read_burst(input txn_t t);
    int n;
    int addr;
    bit held;
    bit fired;
    logic [31:0] hold_data;
    logic [6:0]  hold_ctl;
    logic [31:0] keep;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic [1:0]  worst;
    n     = 0;
    held  = 1'b0;
    worst = 2'b00;
    while (n <= t.len) begin
      r_ready_i = ready_roll(t.stall);
      #30;
      if (held) begin
        check_value("r_valid held", 32'(r_valid_o), 32'd1);
        check_value("r_data held", r_data_o, hold_data);
        check_value("r_id/resp/last held", 32'({r_id_o, r_resp_o, r_last_o}), 32'(hold_ctl));
      end
      held      = r_valid_o && !r_ready_i;
      hold_data = r_data_o;
      hold_ctl  = {r_id_o, r_resp_o, r_last_o};
      fired     = r_valid_o && r_ready_i;
      addr      = beat_address(t, n);
      if (fired) begin
        if (addr < axi_mem_pkg::MemBytes) begin
          keep     = lane_keep(addr, t.size);
          exp_data = ref_word(addr) & keep;
          exp_resp = 2'b00;
        end else begin
          keep     = '1;
          exp_data = '0;
          exp_resp = 2'b10;
        end
        // Burst outcome is built from the responses the DUT returned
        if (r_resp_o != 2'b00) worst = r_resp_o;
        check_value("r_id", 32'(r_id_o), t.id);
        check_value("r_data", r_data_o & keep, exp_data);
        check_value("r_resp", 32'(r_resp_o), 32'(exp_resp));
        check_value("r_last", 32'(r_last_o), 32'(n == t.len));
      end
      @(posedge clk_i);
      #5;
      if (fired) begin
        check_value("mon_r_valid", 32'(mon_r_valid_o), 32'd1);
        check_value("mon_r_addr", 32'(mon_r_addr_o), addr);
        check_value("mon_r_data", mon_r_data_o & keep, exp_data);
        check_value("mon_r_id", 32'(mon_r_id_o), t.id);
        check_value("mon_r_beat_count", 32'(mon_r_beat_count_o), n);
        check_value("mon_r_last", 32'(mon_r_last_o), 32'(n == t.len));
        n++;
      end
    end
    r_ready_i = 1'b0;
    check_value("r_resp of burst", 32'(worst), t.resp);
  endtask

  task automatic load_table();
    // wr, chain, id, addr, len, size, burst (0 FIXED 1 INCR 2 WRAP), rand_strb, stall, resp
    txns.push_back('{1'b1, 1'b0, 1, 'h000, 7, 2, 1, 1'b0, 0, 0});
    txns.push_back('{1'b0, 1'b0, 2, 'h000, 7, 2, 1, 1'b0, 0, 0});
    txns.push_back('{1'b1, 1'b0, 3, 'h005, 3, 0, 1, 1'b1, 0, 0});
    txns.push_back('{1'b1, 1'b0, 4, 'h00a, 1, 1, 1, 1'b1, 0, 0});
    txns.push_back('{1'b0, 1'b0, 5, 'h000, 3, 2, 1, 1'b0, 0, 0});
    txns.push_back('{1'b0, 1'b0, 6, 'h005, 3, 0, 1, 1'b0, 0, 0});
    txns.push_back('{1'b1, 1'b0, 7, 'h048, 3, 2, 2, 1'b0, 0, 0});
    txns.push_back('{1'b0, 1'b0, 8, 'h048, 3, 2, 2, 1'b0, 0, 0});
    txns.push_back('{1'b1, 1'b0, 9, 'h060, 3, 2, 0, 1'b0, 0, 0});
    txns.push_back('{1'b0, 1'b0, 10, 'h060, 1, 2, 0, 1'b0, 0, 0});
    // Last two beats fall beyond the end of memory
    txns.push_back('{1'b1, 1'b0, 11, 'h3f8, 3, 2, 1, 1'b0, 0, 2});
    txns.push_back('{1'b0, 1'b0, 12, 'h3f8, 3, 2, 1, 1'b0, 0, 2});
    txns.push_back('{1'b1, 1'b0, 13, 'h100, 7, 2, 1, 1'b0, 2, 0});
    txns.push_back('{1'b0, 1'b0, 14, 'h100, 7, 2, 1, 1'b0, 2, 0});
    // Chained rows share one address phase and fill the request queue
    txns.push_back('{1'b1, 1'b1, 1, 'h200, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b1, 1'b1, 2, 'h210, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b1, 1'b1, 3, 'h220, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b1, 1'b0, 4, 'h230, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b0, 1'b1, 5, 'h200, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b0, 1'b1, 6, 'h210, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b0, 1'b1, 7, 'h220, 3, 2, 1, 1'b0, 1, 0});
    txns.push_back('{1'b0, 1'b0, 8, 'h230, 3, 2, 1, 1'b0, 1, 0});
  endtask

  initial begin
    int i;
    int j;
    int k;
    int beats;
    int exp_w_beats;
    int exp_r_beats;
    int errs_before;
    txn_t t;
    lcg_state   = 32'd45;
    beats       = 0;
    exp_w_beats = 0;
    exp_r_beats = 0;
    load_table();
    for (i = 0; i < txns.size(); i++) begin
      beats += txns[i].len + 1;
      if (txns[i].wr) exp_w_beats += txns[i].len + 1;
      else exp_r_beats += txns[i].len + 1;
    end
    cycle_limit = 40 * beats + 200;

    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_size_i  = '0;
    aw_burst_i = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    ar_size_i  = '0;
    ar_burst_i = '0;
    r_ready_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    #30;
    check_value("aw_ready after reset", 32'(aw_ready_o), 32'd1);
    check_value("ar_ready after reset", 32'(ar_ready_o), 32'd1);
    check_value("w_ready after reset", 32'(w_ready_o), 32'd0);
    check_value("b_valid after reset", 32'(b_valid_o), 32'd0);
    check_value("r_valid after reset", 32'(r_valid_o), 32'd0);
    check_value("mon_w_valid after reset", 32'(mon_w_valid_o), 32'd0);
    check_value("mon_r_valid after reset", 32'(mon_r_valid_o), 32'd0);
    $display("test reset: done with %0d mismatches", err_count);
    @(posedge clk_i);
    #5;

    i = 0;
    while (i < txns.size()) begin
      j = i;
      while (txns[j].chain && j + 1 < txns.size()) j++;
      issue_addrs(i, j);
      for (k = i; k <= j; k++) begin
        t = txns[k];
        errs_before = err_count;
        if (t.wr) begin
          write_burst(t);
          take_b(t);
        end else begin
          read_burst(t);
        end
        $display("test %0d: %s id %0d addr 0x%0h len %0d burst %0d done with %0d mismatches",
                 k, t.wr ? "write" : "read", t.id, t.addr, t.len, t.burst,
                 err_count - errs_before);
      end
      i = j + 1;
    end

    repeat (2) @(posedge clk_i);
    #5;
    check_value("mon_w beat total", mon_w_count, exp_w_beats);
    check_value("mon_r beat total", mon_r_count, exp_r_beats);
    $display("summary: %0d tests, %0d checks, %0d errors", txns.size() + 1, check_count,
             err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
axi_mem_pkg.sv
mem_port_if.sv
beat_mon_if.sv
axi_req_queue.sv
axi_write_engine.sv
axi_read_engine.sv
axi_byte_mem.sv
axi_mem_top.sv
tb_axi_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_mem -f filelist.f --Mdir "$build_dir" -o tb_axi_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/tb_axi_mem" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# The run counts as passed only when the testbench printed its pass line
if grep -qx "TB PASSED" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1
